/* mips_pipe.f */
logic/mips_pkg.sv
logic/controller.sv
logic/regfile.sv
logic/alu.sv
logic/hazard_unit.sv
logic/performance_monitor.sv
logic/datapath.sv
logic/mips_core.sv
verification/clock_gen.sv
verification/tb_mips_core.sv

/* Bender.yml */
package:
  name: mips_pipe

sources:
  - logic/mips_pkg.sv
  - logic/controller.sv
  - logic/regfile.sv
  - logic/alu.sv
  - logic/hazard_unit.sv
  - logic/performance_monitor.sv
  - logic/datapath.sv
  - logic/mips_core.sv
  - target: test
    files:
      - verification/clock_gen.sv
      - verification/tb_mips_core.sv

/* verification/mips_core_golden.txt */
# P: program word (hex) with mnemonic; D: byte address and word (hex)
# S: name, mode (0 exact, 1 cycle base, 2 minimum delta), byte address, data
P
2001005a  addi r1, r0, 0x5a
20220033  addi r2, r1, 0x33
00221820  add r3, r1, r2
00232022  sub r4, r1, r3
00832824  and r5, r4, r3
00a13025  or r6, r5, r1
0086382a  slt r7, r4, r6
ac070100  sw r7, 0x100(r0)
ac040104  sw r4, 0x104(r0)
ac050108  sw r5, 0x108(r0)
ac06010c  sw r6, 0x10c(r0)
ac030110  sw r3, 0x110(r0)
ac020114  sw r2, 0x114(r0)
20090321  addi r9, r0, 0x321
00824830  muladd r9, r4, r2
ac090118  sw r9, 0x118(r0)
8c0a0200  lw r10, 0x200(r0)
214b0100  addi r11, r10, 0x100
ac0b011c  sw r11, 0x11c(r0)
8c0c0204  lw r12, 0x204(r0)
ac0c0120  sw r12, 0x120(r0)
10210002  beq r1, r1, +2 taken
ac0101f0  sw r1, 0x1f0(r0) marker
ac0201f4  sw r2, 0x1f4(r0) marker
10220001  beq r1, r2, +1 not taken
ac010124  sw r1, 0x124(r0)
0800001d  j 29
ac0201f8  sw r2, 0x1f8(r0) marker
ac0301fc  sw r3, 0x1fc(r0) marker
ac030128  sw r3, 0x128(r0)
c00e0001  rdperf r14, retired
ac0e0130  sw r14, 0x130(r0)
c00f0000  rdperf r15, cycles
20100001  addi r16, r0, 1
20110002  addi r17, r0, 2
20120003  addi r18, r0, 3
c0130000  rdperf r19, cycles
ac0f0134  sw r15, 0x134(r0)
ac130138  sw r19, 0x138(r0)
08000027  j 39 halt
D
00000200 12345678
00000204 cafef00d
S
slt        0 00000100 00000001
sub        0 00000104 ffffff73
and        0 00000108 00000063
or         0 0000010c 0000007b
add        0 00000110 000000e7
addi       0 00000114 0000008d
muladd     0 00000118 ffffb578
loaduse    0 0000011c 12345778
loadstore  0 00000120 cafef00d
beq_nt     0 00000124 0000005a
jump       0 00000128 000000e7
perf_instr 0 00000130 0000001a
cycle_a    1 00000134 00000000
cycle_b    2 00000138 00000003

/* verification/tb_mips_core.sv */
`default_nettype none

module tb_mips_core;
    timeunit 1ns;
    timeprecision 1ps;
    import mips_pkg::*;

    localparam int MAX_CYCLES = 2000;
    localparam int MAX_STORES = 64;

    logic  clk;
    logic  reset;
    word_t pc;
    word_t instr;
    word_t dmem_addr;
    word_t dmem_wdata;
    word_t dmem_rdata;
    logic  dmem_we;

    word_t imem [256];
    word_t dmem [256];

    string exp_name [MAX_STORES];
    int    exp_mode [MAX_STORES];   // 0 exact, 1 cycle base, 2 minimum cycle delta
    word_t exp_addr [MAX_STORES];
    word_t exp_data [MAX_STORES];
    int    n_exp;
    int    n_seen;
    int    n_prog;
    word_t cycle_base;

    clock_gen i_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    mips_core i_mips_core (
        .clk        (clk),
        .reset      (reset),
        .pc         (pc),
        .instr      (instr),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    // Both memories answer in the same cycle
    assign instr      = imem[pc[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_we)
            dmem[dmem_addr[9:2]] <= dmem_wdata;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string test, input word_t expected, input word_t actual);
        stop_on_error($sformatf("Mismatch %s: expected %h, actual %h", test, expected, actual));
    endtask

    task automatic load_golden();
        int    fd;
        int    cnt;
        int    mode;
        byte   section;
        string line;
        string name;
        word_t a;
        word_t d;
        section = "-";
        fd = $fopen("verification/mips_core_golden.txt", "r");
        if (fd == 0) begin
            stop_on_error("could not open the golden file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                cnt  = $fgets(line, fd);
                if (cnt > 0 && line.getc(0) != "#") begin
                    if (line.len() <= 2 && (line.getc(0) == "P" || line.getc(0) == "D" ||
                                            line.getc(0) == "S")) begin
                        section = line.getc(0);
                    end else if (section == "P") begin
                        if ($sscanf(line, "%h", d) == 1 && n_prog < 256) begin
                            imem[n_prog] = d;
                            n_prog++;
                        end
                    end else if (section == "D") begin
                        if ($sscanf(line, "%h %h", a, d) == 2)
                            dmem[a[9:2]] = d;
                    end else if (section == "S") begin
                        if ($sscanf(line, "%s %d %h %h", name, mode, a, d) == 4 &&
                            n_exp < MAX_STORES) begin
                            exp_name[n_exp] = name;
                            exp_mode[n_exp] = mode;
                            exp_addr[n_exp] = a;
                            exp_data[n_exp] = d;
                            n_exp++;
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_store();
        if (n_seen >= n_exp) begin
            stop_on_error($sformatf("unexpected store to %h after the last expected store",
                                    dmem_addr));
        end else begin
            assert (dmem_addr == exp_addr[n_seen])
            else report_mismatch({exp_name[n_seen], "_addr"}, exp_addr[n_seen], dmem_addr);
            case (exp_mode[n_seen])
                0: begin
                    assert (dmem_wdata == exp_data[n_seen])
                    else report_mismatch(exp_name[n_seen], exp_data[n_seen], dmem_wdata);
                end
                1: cycle_base = dmem_wdata;
                default: begin
                    assert (dmem_wdata > cycle_base &&
                            dmem_wdata - cycle_base >= exp_data[n_seen])
                    else report_mismatch(exp_name[n_seen], cycle_base + exp_data[n_seen],
                                         dmem_wdata);
                end
            endcase
            n_seen++;
        end
    endtask

    // Outputs sampled mid-cycle away from the active edge
    always @(negedge clk) begin
        if (reset) begin
            assert (dmem_we == 1'b0)
            else report_mismatch("reset_dmem_we", 32'd0, {31'd0, dmem_we});
            assert (pc == '0)
            else report_mismatch("reset_pc", 32'd0, pc);
        end else if (dmem_we) begin
            check_store();
        end
    end

    initial begin
        int    cycles;
        word_t halt_pc;
        n_exp  = 0;
        n_seen = 0;
        n_prog = 0;
        cycle_base = '0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0800_0000 | word_t'(i);          // Self-jumps outside the program
            dmem[i] = word_t'(i * 4) ^ 32'hdead_beef;
        end
        load_golden();
        halt_pc = word_t'((n_prog - 1) * 4);               // Last word jumps to itself

        cycles = 0;
        while (reset !== 1'b0 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (reset !== 1'b0)
            stop_on_error("reset was never released");

        cycles = 0;
        while (!(n_seen == n_exp && pc == halt_pc) && cycles < MAX_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (n_exp == 0) begin
            stop_on_error("the golden file holds no expected stores");
        end else if (n_seen != n_exp || pc != halt_pc) begin
            stop_on_error($sformatf("timed out waiting for stores and halt, %0d of %0d seen",
                                    n_seen, n_exp));
        end else begin
            for (int i = 0; i < 8; i++) begin
                @(negedge clk);                            // Late stores would show here
                assert (pc == halt_pc || pc == halt_pc + 32'd4)
                else report_mismatch("halt_loop_pc", halt_pc, pc);
            end
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verification/clock_gen.sv */
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* logic/mips_core.sv */
`default_nettype none

module mips_core (
    input  logic            clk,
    input  logic            reset,
    output mips_pkg::word_t pc,
    input  mips_pkg::word_t instr,
    output mips_pkg::word_t dmem_addr,
    output mips_pkg::word_t dmem_wdata,
    output logic            dmem_we,
    input  mips_pkg::word_t dmem_rdata
);
    import mips_pkg::*;

    word_t instr_id;
    ctrl_t ctrl;

    // Decode is purely combinational on the IF/ID word
    controller i_controller (
        .instr_id (instr_id),
        .ctrl     (ctrl)
    );

    datapath i_datapath (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .instr_id   (instr_id),
        .pc         (pc),
        .instr      (instr),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

endmodule

`default_nettype wire

/* logic/datapath.sv */
`default_nettype none

module datapath (
    input  logic            clk,
    input  logic            reset,
    input  mips_pkg::ctrl_t ctrl,
    output mips_pkg::word_t instr_id,
    output mips_pkg::word_t pc,
    input  mips_pkg::word_t instr,
    output mips_pkg::word_t dmem_addr,
    output mips_pkg::word_t dmem_wdata,
    output logic            dmem_we,
    input  mips_pkg::word_t dmem_rdata
);
    import mips_pkg::*;

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    logic      stall, flush_id, flush_ex;
    fwd_sel_t  forward_a, forward_b, forward_c;
    word_t     pcplus4, pc_next, pc_branch, pc_jump;
    reg_addr_t rs_id, rt_id, rd_id;
    word_t     rd1, rd2, rd3, signimm, cmp_a, cmp_b;
    logic      pcsrc_id;
    word_t     srca_ex, fwd_b_ex, srcb_ex, srcc_ex, aluout_ex;
    reg_addr_t writereg_ex;
    word_t     result_wb, cycle_cnt, instr_cnt;

    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val,
                                      input word_t mem_val, input word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    // Decode-stage compare sees an ALU result sitting in MEM
    function automatic word_t id_fwd(input reg_addr_t ra, input word_t reg_val,
                                     input ex_mem_t stage);
        if (ra != '0 && stage.regwrite && stage.writereg == ra)
            return stage.aluout;
        else
            return reg_val;
    endfunction

    // Fetch
    assign pcplus4   = pc + 32'd4;
    assign pc_branch = if_id.pcplus4 + {signimm[29:0], 2'b00};
    assign pc_jump   = {if_id.pcplus4[31:28], instr_id[25:0], 2'b00};
    assign pc_next   = ctrl.jump ? pc_jump : (pcsrc_id ? pc_branch : pcplus4);

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            pc <= '0;
        else if (!stall)
            pc <= pc_next;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            if_id <= '0;
        else if (flush_id)
            if_id <= '0;        // Wrong-path fetch becomes a bubble
        else if (!stall)
            if_id <= '{pcplus4: pcplus4, instr: instr};
    end

    // Decode
    assign instr_id = if_id.instr;
    assign rs_id    = instr_id[25:21];
    assign rt_id    = instr_id[20:16];
    assign rd_id    = instr_id[15:11];
    assign signimm  = {{16{instr_id[15]}}, instr_id[15:0]};

    regfile i_regfile (
        .clk (clk),
        .we  (mem_wb.regwrite),
        .ra1 (rs_id),
        .ra2 (rt_id),
        .ra3 (rd_id),           // Accumulator for muladd
        .wa  (mem_wb.writereg),
        .wd  (result_wb),
        .rd1 (rd1),
        .rd2 (rd2),
        .rd3 (rd3)
    );

    assign cmp_a    = id_fwd(rs_id, rd1, ex_mem);
    assign cmp_b    = id_fwd(rt_id, rd2, ex_mem);
    assign pcsrc_id = ctrl.branch && (cmp_a == cmp_b);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex <= ID_EX_BUBBLE;
        end else if (stall || flush_ex) begin
            id_ex <= ID_EX_BUBBLE;
        end else begin
            id_ex.memtoreg   <= ctrl.memtoreg;
            id_ex.memwrite   <= ctrl.memwrite;
            id_ex.alusrc     <= ctrl.alusrc;
            id_ex.regdst     <= ctrl.regdst;
            id_ex.regwrite   <= ctrl.regwrite;
            id_ex.readperf   <= ctrl.readperf;
            id_ex.alucontrol <= ctrl.alucontrol;
            id_ex.srca       <= rd1;
            id_ex.srcb       <= rd2;
            id_ex.srcc       <= rd3;
            id_ex.signimm    <= signimm;
            id_ex.rs         <= rs_id;
            id_ex.rt         <= rt_id;
            id_ex.rd         <= rd_id;
            id_ex.bubble     <= (instr_id == '0);
            id_ex.perf_flag  <= instr_id[0];
        end
    end

    // Execute
    assign forward_c = (id_ex.rd != '0 && ex_mem.regwrite && ex_mem.writereg == id_ex.rd)
                       ? FWD_MEM
                       : (id_ex.rd != '0 && mem_wb.regwrite && mem_wb.writereg == id_ex.rd)
                       ? FWD_WB : FWD_NONE;

    assign srca_ex     = fwd_mux(forward_a, id_ex.srca, ex_mem.aluout, result_wb);
    assign fwd_b_ex    = fwd_mux(forward_b, id_ex.srcb, ex_mem.aluout, result_wb);
    assign srcc_ex     = fwd_mux(forward_c, id_ex.srcc, ex_mem.aluout, result_wb);
    assign srcb_ex     = id_ex.alusrc ? id_ex.signimm : fwd_b_ex;
    assign writereg_ex = id_ex.regdst ? id_ex.rd : id_ex.rt;

    alu i_alu (
        .a       (srca_ex),
        .b       (srcb_ex),
        .c       (srcc_ex),
        .control (id_ex.alucontrol),
        .result  (aluout_ex)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem <= EX_MEM_BUBBLE;
        end else begin
            ex_mem.memtoreg  <= id_ex.memtoreg;
            ex_mem.memwrite  <= id_ex.memwrite;
            ex_mem.regwrite  <= id_ex.regwrite;
            ex_mem.readperf  <= id_ex.readperf;
            ex_mem.aluout    <= aluout_ex;
            ex_mem.writedata <= fwd_b_ex;
            ex_mem.writereg  <= writereg_ex;
            ex_mem.bubble    <= id_ex.bubble;
            ex_mem.perf_flag <= id_ex.perf_flag;
        end
    end

    // Memory
    assign dmem_addr  = ex_mem.aluout;
    assign dmem_wdata = ex_mem.writedata;
    assign dmem_we    = ex_mem.memwrite;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_wb <= MEM_WB_BUBBLE;
        end else begin
            mem_wb.memtoreg  <= ex_mem.memtoreg;
            mem_wb.regwrite  <= ex_mem.regwrite;
            mem_wb.readperf  <= ex_mem.readperf;
            mem_wb.aluout    <= ex_mem.aluout;
            mem_wb.readdata  <= dmem_rdata;
            mem_wb.writereg  <= ex_mem.writereg;
            mem_wb.bubble    <= ex_mem.bubble;
            mem_wb.perf_flag <= ex_mem.perf_flag;
        end
    end

    // Write-back
    always_comb begin
        if (mem_wb.readperf)
            result_wb = mem_wb.perf_flag ? instr_cnt : cycle_cnt;
        else if (mem_wb.memtoreg)
            result_wb = mem_wb.readdata;
        else
            result_wb = mem_wb.aluout;
    end

    // rdperf is only valid at WB, so it stalls dependents like a load
    hazard_unit i_hazard_unit (
        .clk          (clk),
        .reset        (reset),
        .rs_id        (rs_id),
        .rt_id        (rt_id),
        .rs_ex        (id_ex.rs),
        .rt_ex        (id_ex.rt),
        .writereg_ex  (writereg_ex),
        .writereg_mem (ex_mem.writereg),
        .writereg_wb  (mem_wb.writereg),
        .branch_id    (ctrl.branch),
        .jump_id      (ctrl.jump),
        .pcsrc_id     (pcsrc_id),
        .memtoreg_ex  (id_ex.memtoreg | id_ex.readperf),
        .regwrite_ex  (id_ex.regwrite),
        .memtoreg_mem (ex_mem.memtoreg | ex_mem.readperf),
        .regwrite_mem (ex_mem.regwrite),
        .regwrite_wb  (mem_wb.regwrite),
        .stall        (stall),
        .flush_id     (flush_id),
        .flush_ex     (flush_ex),
        .forward_a    (forward_a),
        .forward_b    (forward_b)
    );

    performance_monitor i_performance_monitor (
        .clk       (clk),
        .reset     (reset),
        .bubble_wb (mem_wb.bubble),
        .cycle_cnt (cycle_cnt),
        .instr_cnt (instr_cnt)
    );

endmodule

`default_nettype wire

/* logic/performance_monitor.sv */
`default_nettype none

module performance_monitor (
    input  logic            clk,
    input  logic            reset,
    input  logic            bubble_wb,
    output mips_pkg::word_t cycle_cnt,
    output mips_pkg::word_t instr_cnt
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cycle_cnt <= '0;
            instr_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 32'd1;
            if (!bubble_wb)
                instr_cnt <= instr_cnt + 32'd1; // Retires on leaving WB
        end
    end

endmodule

`default_nettype wire

/* logic/hazard_unit.sv */
`default_nettype none

module hazard_unit (
    input  logic                clk,
    input  logic                reset,
    input  mips_pkg::reg_addr_t rs_id,
    input  mips_pkg::reg_addr_t rt_id,
    input  mips_pkg::reg_addr_t rs_ex,
    input  mips_pkg::reg_addr_t rt_ex,
    input  mips_pkg::reg_addr_t writereg_ex,
    input  mips_pkg::reg_addr_t writereg_mem,
    input  mips_pkg::reg_addr_t writereg_wb,
    input  logic                branch_id,
    input  logic                jump_id,
    input  logic                pcsrc_id,
    input  logic                memtoreg_ex,
    input  logic                regwrite_ex,
    input  logic                memtoreg_mem,
    input  logic                regwrite_mem,
    input  logic                regwrite_wb,
    output logic                stall,
    output logic                flush_id,
    output logic                flush_ex,
    output mips_pkg::fwd_sel_t  forward_a,
    output mips_pkg::fwd_sel_t  forward_b
);
    import mips_pkg::*;

    logic lw_stall;
    logic branch_stall;

    // MEM result is younger, so it wins over WB
    function automatic fwd_sel_t pick_fwd(input reg_addr_t src,
                                          input logic we_mem, input reg_addr_t wr_mem,
                                          input logic we_wb, input reg_addr_t wr_wb);
        if (src != '0 && we_mem && src == wr_mem)
            return FWD_MEM;
        else if (src != '0 && we_wb && src == wr_wb)
            return FWD_WB;
        else
            return FWD_NONE;
    endfunction

    assign forward_a = pick_fwd(rs_ex, regwrite_mem, writereg_mem, regwrite_wb, writereg_wb);
    assign forward_b = pick_fwd(rt_ex, regwrite_mem, writereg_mem, regwrite_wb, writereg_wb);

    assign lw_stall = memtoreg_ex && (writereg_ex == rs_id || writereg_ex == rt_id);

    // Branch compares in decode and needs settled operands
    assign branch_stall = branch_id &&
        ((regwrite_ex && writereg_ex != '0 &&
          (writereg_ex == rs_id || writereg_ex == rt_id)) ||
         (memtoreg_mem && writereg_mem != '0 &&
          (writereg_mem == rs_id || writereg_mem == rt_id)));

    assign stall    = lw_stall || branch_stall;
    assign flush_id = !stall && (pcsrc_id || jump_id);

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            flush_ex <= 1'b0;
        else
            flush_ex <= flush_id;
    end

endmodule

`default_nettype wire

/* logic/alu.sv */
`default_nettype none

module alu (
    input  mips_pkg::word_t     a,
    input  mips_pkg::word_t     b,
    input  mips_pkg::word_t     c,
    input  mips_pkg::alu_ctrl_t control,
    output mips_pkg::word_t     result
);
    import mips_pkg::*;

    word_t product;
    word_t diff;

    assign product = a * b;  // Low half only
    assign diff    = a - b;

    always_comb begin
        case (control)
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_ADD:    result = a + b;
            ALU_MULADD: result = product + c;
            ALU_SUB:    result = diff;
            ALU_SLT:    result = {31'd0, $signed(a) < $signed(b)};
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/regfile.sv */
`default_nettype none

module regfile (
    input  logic                clk,
    input  logic                we,
    input  mips_pkg::reg_addr_t ra1,
    input  mips_pkg::reg_addr_t ra2,
    input  mips_pkg::reg_addr_t ra3,
    input  mips_pkg::reg_addr_t wa,
    input  mips_pkg::word_t     wd,
    output mips_pkg::word_t     rd1,
    output mips_pkg::word_t     rd2,
    output mips_pkg::word_t     rd3
);
    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && wa != '0)
            regs[wa] <= wd;
    end

    // Same-cycle write is visible to the reader
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];
    assign rd3 = (ra3 == '0) ? '0 : (we && wa == ra3) ? wd : regs[ra3];

endmodule

`default_nettype wire

/* logic/controller.sv */
`default_nettype none

module controller (
    input  mips_pkg::word_t instr_id,
    output mips_pkg::ctrl_t ctrl
);
    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr_id[31:26];
    assign funct  = instr_id[5:0];

    always_comb begin
        ctrl = '0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.regdst   = 1'b1;
                ctrl.regwrite = 1'b1;
                case (funct)
                    FN_ADD:    ctrl.alucontrol = ALU_ADD;
                    FN_SUB:    ctrl.alucontrol = ALU_SUB;
                    FN_AND:    ctrl.alucontrol = ALU_AND;
                    FN_OR:     ctrl.alucontrol = ALU_OR;
                    FN_SLT:    ctrl.alucontrol = ALU_SLT;
                    FN_MULADD: ctrl.alucontrol = ALU_MULADD;
                    default:   ctrl = '0; // Zero word lands here too
                endcase
            end
            OP_LW: begin
                ctrl.alusrc     = 1'b1;
                ctrl.memtoreg   = 1'b1;
                ctrl.regwrite   = 1'b1;
                ctrl.alucontrol = ALU_ADD;
            end
            OP_SW: begin
                ctrl.alusrc     = 1'b1;
                ctrl.memwrite   = 1'b1;
                ctrl.alucontrol = ALU_ADD;
            end
            OP_ADDI: begin
                ctrl.alusrc     = 1'b1;
                ctrl.regwrite   = 1'b1;
                ctrl.alucontrol = ALU_ADD;
            end
            OP_BEQ: begin
                ctrl.branch     = 1'b1;
                ctrl.alucontrol = ALU_SUB;
            end
            OP_J:      ctrl.jump = 1'b1;
            OP_RDPERF: begin
                ctrl.regwrite = 1'b1; // Into rt
                ctrl.readperf = 1'b1;
            end
            default:   ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  alu_ctrl_t;
    typedef logic [1:0]  fwd_sel_t;

    localparam alu_ctrl_t ALU_AND    = 3'd0;
    localparam alu_ctrl_t ALU_OR     = 3'd1;
    localparam alu_ctrl_t ALU_ADD    = 3'd2;
    localparam alu_ctrl_t ALU_MULADD = 3'd3;
    localparam alu_ctrl_t ALU_SUB    = 3'd6;
    localparam alu_ctrl_t ALU_SLT    = 3'd7;

    localparam fwd_sel_t FWD_NONE = 2'd0;
    localparam fwd_sel_t FWD_MEM  = 2'd1;
    localparam fwd_sel_t FWD_WB   = 2'd2;

    localparam logic [5:0] OP_RTYPE  = 6'h00;
    localparam logic [5:0] OP_J      = 6'h02;
    localparam logic [5:0] OP_BEQ    = 6'h04;
    localparam logic [5:0] OP_ADDI   = 6'h08;
    localparam logic [5:0] OP_LW     = 6'h23;
    localparam logic [5:0] OP_SW     = 6'h2b;
    localparam logic [5:0] OP_RDPERF = 6'h30;

    localparam logic [5:0] FN_ADD    = 6'h20;
    localparam logic [5:0] FN_SUB    = 6'h22;
    localparam logic [5:0] FN_AND    = 6'h24;
    localparam logic [5:0] FN_OR     = 6'h25;
    localparam logic [5:0] FN_SLT    = 6'h2a;
    localparam logic [5:0] FN_MULADD = 6'h30;

    typedef struct packed {
        logic      memtoreg;
        logic      memwrite;
        logic      alusrc;
        logic      regdst;
        logic      regwrite;
        logic      jump;
        logic      branch;
        logic      readperf;
        alu_ctrl_t alucontrol;
    } ctrl_t;

    typedef struct packed {
        word_t pcplus4;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic      memtoreg;
        logic      memwrite;
        logic      alusrc;
        logic      regdst;
        logic      regwrite;
        logic      readperf;
        alu_ctrl_t alucontrol;
        word_t     srca;
        word_t     srcb;
        word_t     srcc;       // Old rd, muladd only
        word_t     signimm;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic      bubble;
        logic      perf_flag;
    } id_ex_t;

    typedef struct packed {
        logic      memtoreg;
        logic      memwrite;
        logic      regwrite;
        logic      readperf;
        word_t     aluout;
        word_t     writedata;
        reg_addr_t writereg;
        logic      bubble;
        logic      perf_flag;
    } ex_mem_t;

    typedef struct packed {
        logic      memtoreg;
        logic      regwrite;
        logic      readperf;
        word_t     aluout;
        word_t     readdata;
        reg_addr_t writereg;
        logic      bubble;
        logic      perf_flag;
    } mem_wb_t;

    // Empty slots, marked so the retired counter skips them
    localparam id_ex_t  ID_EX_BUBBLE  = '{bubble: 1'b1, default: '0};
    localparam ex_mem_t EX_MEM_BUBBLE = '{bubble: 1'b1, default: '0};
    localparam mem_wb_t MEM_WB_BUBBLE = '{bubble: 1'b1, default: '0};

endpackage

`default_nettype wire
